/* rp_tlp_pkg.sv */
`default_nettype none

package rp_tlp_pkg;

   // ----------------------------------------
   // Field widths
   // ----------------------------------------

   // Length field of DW0, in DWs
   localparam int LEN_W = 10;
   localparam int TAG_W = 8;
   localparam int RID_W = 16;

   // ----------------------------------------
   // Fmt/type byte, DW0 bits 31:24
   // ----------------------------------------

   // Memory write, 3DW header with data
   localparam logic [7:0] FMT_MWR  = 8'h40;
   // Memory read, 3DW header
   localparam logic [7:0] FMT_MRD  = 8'h00;
   // Completion with data
   localparam logic [7:0] FMT_CPLD = 8'h4A;

   // Completion status, DW1 bits 15:13
   localparam logic [2:0] CPL_STS_SC = 3'b000;

   // ----------------------------------------
   // Types
   // ----------------------------------------

   typedef logic [31:0] dw_t;

   // Lower half carries the earlier DW of the beat
   typedef logic [63:0] beat_t;

   // Byte address, wraps inside the shared memory
   typedef logic [31:0] shmem_addr_t;

   // Request header layout
   //   dw0  fmt/type [31:24], length [9:0]
   //   dw1  requester ID [31:16], tag [15:8], last BE [7:4], first BE [3:0]
   //   dw2  address [31:2]
   // Completion header layout
   //   dw0  fmt/type [31:24], length [9:0]
   //   dw1  completer ID [31:16], status [15:13], byte count [11:0]
   //   dw2  requester ID [31:16], tag [15:8], lower address [6:0]
   typedef struct packed {
      dw_t dw2;
      dw_t dw1;
      dw_t dw0;
   } tlp_hdr_t;

endpackage

`default_nettype wire

/* rp_tlp_if.sv */
`timescale 1ns/1ps
`default_nettype none

// QW write port into the shared memory, one QW per cycle
interface shmem_wr_if;
   import rp_tlp_pkg::*;

   logic        we;
   shmem_addr_t addr;
   beat_t       data;
   logic [7:0]  be;

   modport master (output we, addr, data, be);
   modport slave  (input we, addr, data, be);
endinterface

// Read request handed from the rx decoder to the completion builder
interface cpl_req_if;
   import rp_tlp_pkg::*;

   logic             req;
   logic             ack;
   logic [TAG_W-1:0] tag;
   logic [RID_W-1:0] req_id;
   shmem_addr_t      addr;
   logic [LEN_W-1:0] len_dw;

   modport master (output req, tag, req_id, addr, len_dw, input ack);
   modport slave  (input req, tag, req_id, addr, len_dw, output ack);
endinterface

`default_nettype wire

/* rx_tlp_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_tlp_decoder #(
   parameter int unsigned MEM_QW = 256
) (
   input  logic              clk_in,
   input  logic              rstn,
   input  logic              rx_st_valid,
   input  logic              rx_st_sop,
   input  logic              rx_st_eop,
   input  rp_tlp_pkg::beat_t rx_st_data,
   output logic              rx_st_ready,
   shmem_wr_if.master        wr,
   cpl_req_if.master         req
);
   import rp_tlp_pkg::*;

   localparam shmem_addr_t ADDR_MASK = shmem_addr_t'(MEM_QW * 8 - 1);

   typedef enum logic [2:0] {
      S_IDLE,
      S_DW2,
      S_WDATA,
      S_RDEOP,
      S_REQ,
      S_SKIP
   } rx_state_t;

   rx_state_t        state;
   rx_state_t        state_nxt;
   tlp_hdr_t         hdr;
   shmem_addr_t      qw_addr;
   logic [LEN_W-1:0] rem_dw;
   logic             first_dw;
   logic             beat;
   logic             wr_phase;
   logic [7:0]       hdr_fmt;
   logic [LEN_W-1:0] hdr_len;
   logic [3:0]       be_lo;
   logic [3:0]       be_hi;
   logic [LEN_W-1:0] rem_lo;
   logic [LEN_W-1:0] rem_hi;

   // Enables of one payload DW from its position in the TLP
   function automatic logic [3:0] lane_be(
      input logic [LEN_W-1:0] rem,
      input logic             first,
      input logic [3:0]       fbe,
      input logic [3:0]       lbe
   );
      logic [3:0] be;
      if (rem == '0)
         be = 4'h0;
      else if (first)
         be = fbe;
      else if (rem == LEN_W'(1))
         be = lbe;
      else
         be = 4'hF;
      return be;
   endfunction

   assign beat    = rx_st_valid & rx_st_ready;
   assign hdr_fmt = hdr.dw0[31:24];
   assign hdr_len = hdr.dw0[LEN_W-1:0];

   // ----------------------------------------
   // Byte enables per beat
   // ----------------------------------------

   // Lane position equals the DW position inside the memory QW
   always_comb
   begin
      be_lo  = 4'h0;
      be_hi  = 4'h0;
      rem_lo = rem_dw;
      rem_hi = rem_dw;
      if (state == S_DW2)
      begin
         // Non-QW-aligned address puts the first DW next to DW2
         if (rx_st_data[2])
         begin
            be_hi  = lane_be(hdr_len, 1'b1, hdr.dw1[3:0], hdr.dw1[7:4]);
            rem_hi = hdr_len - 1'b1;
         end
         else
            rem_hi = hdr_len;
      end
      else if (state == S_WDATA)
      begin
         be_lo  = lane_be(rem_dw, first_dw, hdr.dw1[3:0], hdr.dw1[7:4]);
         rem_lo = (rem_dw != '0) ? rem_dw - 1'b1 : '0;
         be_hi  = lane_be(rem_lo, 1'b0, hdr.dw1[3:0], hdr.dw1[7:4]);
         rem_hi = (rem_lo != '0) ? rem_lo - 1'b1 : '0;
      end
   end

   assign wr_phase = (state == S_WDATA) || ((state == S_DW2) && (hdr_fmt == FMT_MWR));
   assign wr.we    = beat && wr_phase && ({be_hi, be_lo} != 8'h00);
   assign wr.be    = {be_hi, be_lo};
   assign wr.data  = rx_st_data;
   assign wr.addr  = (state == S_DW2) ? ({rx_st_data[31:3], 3'b000} & ADDR_MASK)
                                      : (qw_addr & ADDR_MASK);

   // ----------------------------------------
   // Packet FSM
   // ----------------------------------------

   always_comb
   begin
      state_nxt = state;
      case (state)
         S_IDLE:
         begin
            if (beat && rx_st_sop && !rx_st_eop)
               state_nxt = S_DW2;
         end
         S_DW2:
         begin
            if (beat)
            begin
               if (hdr_fmt == FMT_MWR)
                  state_nxt = rx_st_eop ? S_IDLE : S_WDATA;
               else if (hdr_fmt == FMT_MRD)
                  state_nxt = rx_st_eop ? S_REQ : S_RDEOP;
               else
                  state_nxt = rx_st_eop ? S_IDLE : S_SKIP;
            end
         end
         S_WDATA, S_SKIP:
         begin
            if (beat && rx_st_eop)
               state_nxt = S_IDLE;
         end
         S_RDEOP:
         begin
            if (beat && rx_st_eop)
               state_nxt = S_REQ;
         end
         S_REQ:
         begin
            if (req.ack)
               state_nxt = S_IDLE;
         end
         default:
            state_nxt = S_IDLE;
      endcase
   end

   // Stream stalls while a read waits for the builder
   always_ff @(posedge clk_in)
   begin
      if (!rstn)
      begin
         state       <= S_IDLE;
         rx_st_ready <= 1'b0;
      end
      else
      begin
         state       <= state_nxt;
         rx_st_ready <= (state_nxt != S_REQ);
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (beat && (state == S_IDLE) && rx_st_sop)
      begin
         hdr.dw0 <= rx_st_data[31:0];
         hdr.dw1 <= rx_st_data[63:32];
      end
      if (beat && (state == S_DW2))
      begin
         hdr.dw2  <= rx_st_data[31:0];
         qw_addr  <= {rx_st_data[31:3], 3'b000} + (rx_st_data[2] ? 32'd8 : 32'd0);
         rem_dw   <= rem_hi;
         first_dw <= ~rx_st_data[2];
      end
      if (beat && (state == S_WDATA))
      begin
         qw_addr  <= qw_addr + 32'd8;
         rem_dw   <= rem_hi;
         first_dw <= 1'b0;
      end
   end

   // Request fields stay steady until the ack
   assign req.req    = (state == S_REQ);
   assign req.tag    = hdr.dw1[15:8];
   assign req.req_id = hdr.dw1[31:16];
   assign req.addr   = {hdr.dw2[31:2], 2'b00};
   assign req.len_dw = hdr_len;

endmodule

`default_nettype wire

/* shmem_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module shmem_ram #(
   parameter int unsigned MEM_QW = 256
) (
   input  logic                    clk_in,
   shmem_wr_if.slave               wr,
   input  logic                    rd_en,
   input  rp_tlp_pkg::shmem_addr_t rd_addr,
   output rp_tlp_pkg::beat_t       rd_data
);
   import rp_tlp_pkg::*;

   // MEM_QW is a power of two, so upper address bits wrap
   localparam int unsigned IDX_W = $clog2(MEM_QW);

   beat_t            mem [MEM_QW];
   logic [IDX_W-1:0] wr_idx;
   logic [IDX_W-1:0] rd_idx;

   // QW index sits above the byte offset
   assign wr_idx = wr.addr[3 +: IDX_W];
   assign rd_idx = rd_addr[3 +: IDX_W];

   // ----------------------------------------
   // Byte write port
   // ----------------------------------------

   always_ff @(posedge clk_in)
   begin
      if (wr.we)
      begin
         for (int b = 0; b < 8; b++)
         begin
            if (wr.be[b])
               mem[wr_idx][b*8 +: 8] <= wr.data[b*8 +: 8];
         end
      end
   end

   // Whole QW out, one cycle after rd_en
   always_ff @(posedge clk_in)
   begin
      if (rd_en)
         rd_data <= mem[rd_idx];
   end

endmodule

`default_nettype wire

/* cpl_tlp_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module cpl_tlp_builder #(
   parameter int unsigned                  MAX_RD_DW = 16,
   parameter logic [rp_tlp_pkg::RID_W-1:0] CPL_ID    = 16'h0100
) (
   input  logic                    clk_in,
   input  logic                    rstn,
   cpl_req_if.slave                req,
   output logic                    rd_en,
   output rp_tlp_pkg::shmem_addr_t rd_addr,
   input  rp_tlp_pkg::beat_t       rd_data,
   output logic                    tx_st_valid,
   output logic                    tx_st_sop,
   output logic                    tx_st_eop,
   output rp_tlp_pkg::beat_t       tx_st_data,
   input  logic                    tx_st_ready
);
   import rp_tlp_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_HDR,
      S_DATA
   } tx_state_t;

   tx_state_t        state;
   tlp_hdr_t         cpl_hdr;
   logic [LEN_W-1:0] len_srv;
   logic [LEN_W:0]   qw_sum;
   logic [LEN_W-1:0] fetch_left;
   logic [LEN_W-1:0] send_left;
   logic             dw2_pend;
   logic             dw2_only;
   logic             last_lo;
   logic             take;
   logic             pop;
   // Two-entry fetch buffer
   beat_t            fbuf [2];
   logic             wr_sel;
   logic             rd_sel;
   logic [1:0]       fcount;
   logic             rd_vld;
   logic [1:0]       occ;

   assign take    = (state == S_IDLE) && req.req;
   assign len_srv = (req.len_dw > LEN_W'(MAX_RD_DW)) ? LEN_W'(MAX_RD_DW) : req.len_dw;
   // QWs touched by the read, counting the odd start DW
   assign qw_sum  = {1'b0, len_srv} + {{LEN_W{1'b0}}, req.addr[2]} + (LEN_W+1)'(1);

   // Aligned completions send DW2 alone in beat two
   assign dw2_only = dw2_pend && !cpl_hdr.dw2[2];

   // ----------------------------------------
   // Tx beat select
   // ----------------------------------------

   always_comb
   begin
      tx_st_valid = 1'b0;
      tx_st_sop   = 1'b0;
      tx_st_eop   = 1'b0;
      tx_st_data  = fbuf[rd_sel];
      case (state)
         S_HDR:
         begin
            tx_st_valid = 1'b1;
            tx_st_sop   = 1'b1;
            tx_st_data  = {cpl_hdr.dw1, cpl_hdr.dw0};
         end
         S_DATA:
         begin
            if (dw2_only)
            begin
               tx_st_valid = 1'b1;
               tx_st_data  = {32'h0, cpl_hdr.dw2};
            end
            else
            begin
               tx_st_valid = (fcount != 2'd0);
               tx_st_eop   = (fcount != 2'd0) && (send_left == LEN_W'(1));
               if (dw2_pend)
                  tx_st_data[31:0] = cpl_hdr.dw2;
               else if ((send_left == LEN_W'(1)) && last_lo)
                  tx_st_data[63:32] = 32'h0;
            end
         end
         default:
         begin
         end
      endcase
   end

   assign pop = (state == S_DATA) && !dw2_only && (fcount != 2'd0) && tx_st_ready;

   // Fetch ahead while the buffer and the read in flight leave room
   assign occ   = fcount + {1'b0, rd_vld};
   assign rd_en = (state != S_IDLE) && (fetch_left != '0) && ((occ != 2'd2) || pop);

   always_ff @(posedge clk_in)
   begin
      if (!rstn)
      begin
         state      <= S_IDLE;
         req.ack    <= 1'b0;
         fetch_left <= '0;
         send_left  <= '0;
         dw2_pend   <= 1'b0;
         rd_vld     <= 1'b0;
         wr_sel     <= 1'b0;
         rd_sel     <= 1'b0;
         fcount     <= 2'd0;
      end
      else
      begin
         req.ack <= take;
         case (state)
            S_IDLE:
            begin
               if (take)
               begin
                  state      <= S_HDR;
                  fetch_left <= qw_sum[LEN_W:1];
                  send_left  <= qw_sum[LEN_W:1];
                  dw2_pend   <= 1'b1;
               end
            end
            S_HDR:
            begin
               if (tx_st_ready)
                  state <= S_DATA;
            end
            S_DATA:
            begin
               if (tx_st_valid && tx_st_ready)
                  dw2_pend <= 1'b0;
               if (pop)
                  send_left <= send_left - 1'b1;
               if (tx_st_eop && tx_st_ready)
                  state <= S_IDLE;
            end
            default:
               state <= S_IDLE;
         endcase
         if (rd_en)
            fetch_left <= fetch_left - 1'b1;
         rd_vld <= rd_en;
         if (rd_vld)
            wr_sel <= ~wr_sel;
         if (pop)
            rd_sel <= ~rd_sel;
         fcount <= fcount + {1'b0, rd_vld} - {1'b0, pop};
      end
   end

   // Completion header and read pointer
   always_ff @(posedge clk_in)
   begin
      if (take)
      begin
         cpl_hdr.dw0 <= {FMT_CPLD, 14'h0, len_srv};
         cpl_hdr.dw1 <= {CPL_ID, CPL_STS_SC, 1'b0, len_srv, 2'b00};
         cpl_hdr.dw2 <= {req.req_id, req.tag, 1'b0, req.addr[6:2], 2'b00};
         // Last DW lands in the lower lane of the final beat
         last_lo     <= req.addr[2] ^ len_srv[0];
         rd_addr     <= {req.addr[31:3], 3'b000};
      end
      else if (rd_en)
         rd_addr <= rd_addr + 32'd8;
      if (rd_vld)
         fbuf[wr_sel] <= rd_data;
   end

endmodule

`default_nettype wire

/* rp_shmem_target.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_shmem_target #(
   parameter int unsigned                  MEM_QW    = 256,
   parameter int unsigned                  MAX_RD_DW = 16,
   parameter logic [rp_tlp_pkg::RID_W-1:0] CPL_ID    = 16'h0100
) (
   input  logic              clk_in,
   input  logic              rstn,
   // Rx stream
   input  logic              rx_st_valid,
   input  logic              rx_st_sop,
   input  logic              rx_st_eop,
   input  rp_tlp_pkg::beat_t rx_st_data,
   output logic              rx_st_ready,
   // Tx stream
   output logic              tx_st_valid,
   output logic              tx_st_sop,
   output logic              tx_st_eop,
   output rp_tlp_pkg::beat_t tx_st_data,
   input  logic              tx_st_ready
);
   import rp_tlp_pkg::*;

   // ----------------------------------------
   // Internal links
   // ----------------------------------------

   shmem_wr_if  wr_bus ();
   cpl_req_if   req_bus ();

   logic        rd_en;
   shmem_addr_t rd_addr;
   beat_t       rd_data;

   rx_tlp_decoder #(
      .MEM_QW      (MEM_QW)
   ) rx_tlp_decoder_inst (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .rx_st_valid (rx_st_valid),
      .rx_st_sop   (rx_st_sop),
      .rx_st_eop   (rx_st_eop),
      .rx_st_data  (rx_st_data),
      .rx_st_ready (rx_st_ready),
      .wr          (wr_bus.master),
      .req         (req_bus.master)
   );

   shmem_ram #(
      .MEM_QW  (MEM_QW)
   ) shmem_ram_inst (
      .clk_in  (clk_in),
      .wr      (wr_bus.slave),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   cpl_tlp_builder #(
      .MAX_RD_DW   (MAX_RD_DW),
      .CPL_ID      (CPL_ID)
   ) cpl_tlp_builder_inst (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .req         (req_bus.slave),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .tx_st_valid (tx_st_valid),
      .tx_st_sop   (tx_st_sop),
      .tx_st_eop   (tx_st_eop),
      .tx_st_data  (tx_st_data),
      .tx_st_ready (tx_st_ready)
   );

endmodule

`default_nettype wire

/* tb_rp_shmem_target_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rp_shmem_target_chk (
   input logic              clk_in,
   input logic              rstn,
   input logic              tx_st_valid,
   input logic              tx_st_sop,
   input logic              tx_st_eop,
   input rp_tlp_pkg::beat_t tx_st_data,
   input logic              tx_st_ready
);

   int unsigned fails = 0;
   logic        in_pkt;

   // Inside a tx TLP after a beat without eop
   always_ff @(posedge clk_in)
   begin
      if (!rstn)
         in_pkt <= 1'b0;
      else if (tx_st_valid && tx_st_ready)
         in_pkt <= !tx_st_eop;
   end

   tx_flags_valid: assert property (@(posedge clk_in) disable iff (!rstn)
      (tx_st_sop || tx_st_eop) |-> tx_st_valid)
   else
   begin
      $error("tx_st_sop or tx_st_eop high without tx_st_valid");
      fails++;
   end

   tx_hold: assert property (@(posedge clk_in) disable iff (!rstn)
      (tx_st_valid && !tx_st_ready) |=>
      (tx_st_valid && $stable(tx_st_sop) && $stable(tx_st_eop) && $stable(tx_st_data)))
   else
   begin
      $error("tx beat changed while tx_st_ready was low");
      fails++;
   end

   tx_sop_order: assert property (@(posedge clk_in) disable iff (!rstn)
      (tx_st_valid && tx_st_ready && tx_st_sop) |-> !in_pkt)
   else
   begin
      $error("tx sop before the eop of the previous TLP");
      fails++;
   end

   tx_eop_order: assert property (@(posedge clk_in) disable iff (!rstn)
      (tx_st_valid && tx_st_ready && !tx_st_sop) |-> in_pkt)
   else
   begin
      $error("tx beat outside a TLP");
      fails++;
   end

endmodule

`default_nettype wire

/* tb_rp_shmem_target.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rp_shmem_target;
   import rp_tlp_pkg::*;

   localparam int unsigned MEM_QW    = 256;
   localparam int unsigned MAX_RD_DW = 16;
   localparam logic [15:0] CPL_ID    = 16'h0100;
   localparam int MEM_BYTES = MEM_QW * 8;
   localparam int N_ITER    = 16;
   // Fill, three write/read tests, back-pressure and unsupported mix
   localparam int N_PKTS      = MEM_BYTES / 256 + 6 * N_ITER + 3 * N_ITER + 4 * N_ITER;
   localparam int WATCHDOG_NS = N_PKTS * 64 * 10 + 2000;

   logic  clk_in = 1'b0;
   logic  rstn;
   logic  rx_st_valid;
   logic  rx_st_sop;
   logic  rx_st_eop;
   beat_t rx_st_data;
   logic  rx_st_ready;
   logic  tx_st_valid;
   logic  tx_st_sop;
   logic  tx_st_eop;
   beat_t tx_st_data;
   logic  tx_st_ready;

   integer     seed = 63310;
   string      test_name = "reset";
   int         errors = 0;
   int         rd_sent = 0;
   int         sop_seen = 0;
   int         cpl_count = 0;
   logic       sop_prev = 1'b0;
   logic       bp_on = 1'b0;
   logic [7:0] mem_model [MEM_BYTES];
   beat_t      pkt_q [$];
   beat_t      exp_beat_q [$];
   logic       exp_sop_q [$];
   logic       exp_eop_q [$];

   rp_shmem_target #(
      .MEM_QW      (MEM_QW),
      .MAX_RD_DW   (MAX_RD_DW),
      .CPL_ID      (CPL_ID)
   ) rp_shmem_target_inst (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .rx_st_valid (rx_st_valid),
      .rx_st_sop   (rx_st_sop),
      .rx_st_eop   (rx_st_eop),
      .rx_st_data  (rx_st_data),
      .rx_st_ready (rx_st_ready),
      .tx_st_valid (tx_st_valid),
      .tx_st_sop   (tx_st_sop),
      .tx_st_eop   (tx_st_eop),
      .tx_st_data  (tx_st_data),
      .tx_st_ready (tx_st_ready)
   );

   bind rp_shmem_target tb_rp_shmem_target_chk stream_chk_inst (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .tx_st_valid (tx_st_valid),
      .tx_st_sop   (tx_st_sop),
      .tx_st_eop   (tx_st_eop),
      .tx_st_data  (tx_st_data),
      .tx_st_ready (tx_st_ready)
   );

   always #5 clk_in = ~clk_in;

   function automatic int rnd_below(input int n);
      return ($random(seed) & 32'h7FFF_FFFF) % n;
   endfunction

   // One DW of the memory model
   // Bytes wrap at the end of memory
   function automatic dw_t model_dw(input int addr);
      dw_t d;
      for (int b = 0; b < 4; b++)
         d[b*8 +: 8] = mem_model[(addr + b) % MEM_BYTES];
      return d;
   endfunction

   task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      errors++;
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
   endtask

   task automatic report_fault(input string what);
      errors++;
      $display("Test %s went wrong: %s", test_name, what);
   endtask

   // ----------------------------------------
   // Rx stream driver
   // ----------------------------------------

   task automatic send_beat(input beat_t data, input logic sop, input logic eop);
      logic taken;
      rx_st_valid = 1'b1;
      rx_st_sop   = sop;
      rx_st_eop   = eop;
      rx_st_data  = data;
      // Ready is a register, steady until the next rising edge
      do
      begin
         taken = rx_st_ready;
         @(negedge clk_in);
      end
      while (!taken);
   endtask

   task automatic send_pkt();
      if (rnd_below(4) == 0)
         @(negedge clk_in);
      for (int i = 0; i < pkt_q.size(); i++)
         send_beat(pkt_q[i], i == 0, i == pkt_q.size() - 1);
      rx_st_valid = 1'b0;
      rx_st_sop   = 1'b0;
      rx_st_eop   = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_beat_q.size() != 0)
         @(negedge clk_in);
   endtask

   task automatic send_write(input int addr, input int len, input logic [3:0] fbe,
                             input logic [3:0] lbe);
      dw_t         pay [$];
      logic [3:0]  be;
      logic [23:0] id_tag;
      dw_t         a_dw;
      int          i;
      // No write overtakes a completion still being fetched
      wait_drain();
      id_tag = $random(seed);
      a_dw   = dw_t'(addr);
      for (int k = 0; k < len; k++)
      begin
         pay.push_back($random(seed));
         if (k == 0)
            be = fbe;
         else if (k == len - 1)
            be = lbe;
         else
            be = 4'hF;
         for (int b = 0; b < 4; b++)
         begin
            if (be[b])
               mem_model[(addr + 4 * k + b) % MEM_BYTES] = pay[k][b*8 +: 8];
         end
      end
      pkt_q.delete();
      pkt_q.push_back({id_tag, lbe, fbe, FMT_MWR, 14'h0, LEN_W'(len)});
      if (a_dw[2])
      begin
         pkt_q.push_back({pay[0], a_dw});
         i = 1;
      end
      else
      begin
         pkt_q.push_back({32'h0, a_dw});
         i = 0;
      end
      // Junk in the unused upper half of the last beat
      while (i < len)
      begin
         pkt_q.push_back({(i + 1 < len) ? pay[i + 1] : dw_t'($random(seed)), pay[i]});
         i += 2;
      end
      send_pkt();
   endtask

   task automatic send_read(input int addr, input int len);
      logic [23:0] id_tag;
      dw_t         a_dw;
      dw_t         dw2;
      dw_t         d [$];
      beat_t       cq [$];
      int          i;
      id_tag = $random(seed);
      a_dw   = dw_t'(addr);
      for (int k = 0; k < len; k++)
         d.push_back(model_dw(addr + 4 * k));
      dw2 = {id_tag, 1'b0, a_dw[6:2], 2'b00};
      cq.push_back({CPL_ID, CPL_STS_SC, 1'b0, 12'(len * 4), FMT_CPLD, 14'h0, LEN_W'(len)});
      if (a_dw[2])
      begin
         cq.push_back({d[0], dw2});
         i = 1;
      end
      else
      begin
         cq.push_back({32'h0, dw2});
         i = 0;
      end
      while (i < len)
      begin
         cq.push_back({(i + 1 < len) ? d[i + 1] : 32'h0, d[i]});
         i += 2;
      end
      for (int k = 0; k < cq.size(); k++)
      begin
         exp_beat_q.push_back(cq[k]);
         exp_sop_q.push_back(k == 0);
         exp_eop_q.push_back(k == cq.size() - 1);
      end
      pkt_q.delete();
      pkt_q.push_back({id_tag, (len > 1) ? 4'hF : 4'h0, 4'hF, FMT_MRD, 14'h0, LEN_W'(len)});
      pkt_q.push_back({32'h0, a_dw});
      send_pkt();
      rd_sent++;
      // Decoder holds the request, so the rx stream stalls
      if (rx_st_ready !== 1'b0)
         report_value("rx_st_ready after read eop", 64'h0, rx_st_ready);
   endtask

   // Messages, I/O and configuration TLPs
   task automatic send_other(input int addr);
      logic [7:0]  fmt;
      logic [23:0] id_tag;
      int          n;
      case (rnd_below(8))
         0: fmt = 8'h30;
         1: fmt = 8'h70;
         2: fmt = 8'h02;
         3: fmt = 8'h42;
         4: fmt = 8'h04;
         5: fmt = 8'h44;
         6: fmt = 8'h05;
         default: fmt = 8'h45;
      endcase
      n = 2 + rnd_below(3);
      id_tag = $random(seed);
      pkt_q.delete();
      // Enables all set and address inside the range read back next
      pkt_q.push_back({id_tag, 8'hFF, fmt, 14'h0, 10'd1});
      pkt_q.push_back({dw_t'($random(seed)), dw_t'(addr)});
      for (int k = 1; k < n; k++)
         pkt_q.push_back({dw_t'($random(seed)), dw_t'($random(seed))});
      send_pkt();
   endtask

   // ----------------------------------------
   // Tx side
   // ----------------------------------------

   always @(negedge clk_in)
      tx_st_ready = bp_on ? (rnd_below(2) == 1) : 1'b1;

   task automatic check_tx_beat();
      beat_t exp_data;
      logic  exp_sop;
      logic  exp_eop;
      if (exp_beat_q.size() == 0)
         report_fault("completion beat arrived with no read outstanding");
      else
      begin
         exp_data = exp_beat_q.pop_front();
         exp_sop  = exp_sop_q.pop_front();
         exp_eop  = exp_eop_q.pop_front();
         if (tx_st_data !== exp_data)
            report_value("tx_st_data", exp_data, tx_st_data);
         if (tx_st_sop !== exp_sop)
            report_value("tx_st_sop", exp_sop, tx_st_sop);
         if (tx_st_eop !== exp_eop)
            report_value("tx_st_eop", exp_eop, tx_st_eop);
         if (tx_st_eop)
            cpl_count++;
      end
   endtask

   always @(posedge clk_in)
   begin
      if (!rstn)
         sop_prev = 1'b0;
      else
      begin
         if (tx_st_valid && tx_st_sop && !sop_prev)
            sop_seen++;
         sop_prev = tx_st_valid && tx_st_sop;
         // A read is pending until the builder has started its completion
         if (rx_st_ready && (sop_seen < rd_sent))
            report_fault("rx_st_ready went high while a read request was pending");
         if (tx_st_valid && tx_st_ready)
            check_tx_beat();
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, %0d completion beats still expected",
               WATCHDOG_NS, exp_beat_q.size());
      $display("Some tests failed");
      $finish;
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------

   initial
   begin
      int          addr;
      int          len;
      int unsigned assert_fails;
      rstn        = 1'b0;
      rx_st_valid = 1'b0;
      rx_st_sop   = 1'b0;
      rx_st_eop   = 1'b0;
      rx_st_data  = '0;
      tx_st_ready = 1'b1;
      for (int c = 0; c < 10; c++)
      begin
         @(negedge clk_in);
         if ({tx_st_valid, tx_st_sop, tx_st_eop, rx_st_ready} !== 4'b0000)
            report_value("outputs in reset", 64'h0,
                         {tx_st_valid, tx_st_sop, tx_st_eop, rx_st_ready});
      end
      rstn = 1'b1;
      @(negedge clk_in);
      if (rx_st_ready !== 1'b1)
         report_value("rx_st_ready after reset", 64'h1, rx_st_ready);

      // Whole memory gets known contents first
      test_name = "fill";
      for (int a = 0; a < MEM_BYTES; a += 256)
         send_write(a, 64, 4'hF, 4'hF);

      test_name = "aligned";
      for (int n = 0; n < N_ITER; n++)
      begin
         addr = rnd_below(MEM_QW) * 8;
         len  = 1 + rnd_below(MAX_RD_DW);
         send_write(addr, len, 4'hF, (len > 1) ? 4'hF : 4'h0);
         send_read(addr, len);
      end

      test_name = "unaligned";
      for (int n = 0; n < N_ITER; n++)
      begin
         addr = rnd_below(MEM_QW) * 8 + 4;
         len  = 1 + rnd_below(MAX_RD_DW);
         send_write(addr, len, 4'hF, (len > 1) ? 4'hF : 4'h0);
         send_read(addr, len);
      end

      test_name = "byte_enable";
      for (int n = 0; n < N_ITER; n++)
      begin
         addr = rnd_below(MEM_QW * 2) * 4;
         len  = 1 + rnd_below(MAX_RD_DW);
         send_write(addr, len, 4'(rnd_below(16)), 4'(rnd_below(16)));
         send_read(addr, len);
      end

      // Two reads in a row keep the decoder waiting on a busy builder
      test_name = "backpressure";
      bp_on = 1'b1;
      for (int n = 0; n < N_ITER; n++)
      begin
         addr = rnd_below(MEM_QW * 2) * 4;
         len  = 1 + rnd_below(MAX_RD_DW);
         send_write(addr, len, 4'hF, 4'hF);
         send_read(addr, len);
         send_read(rnd_below(MEM_QW * 2) * 4, 1 + rnd_below(MAX_RD_DW));
      end
      wait_drain();
      bp_on = 1'b0;

      test_name = "unsupported";
      for (int n = 0; n < N_ITER; n++)
      begin
         addr = rnd_below(MEM_QW * 2) * 4;
         len  = 1 + rnd_below(MAX_RD_DW);
         send_write(addr, len, 4'hF, 4'hF);
         send_other(addr);
         send_other(addr);
         send_read(addr, len);
      end

      test_name = "final";
      wait_drain();
      repeat (20) @(negedge clk_in);
      if (cpl_count != rd_sent)
         report_value("completion count", rd_sent, cpl_count);
      if (sop_seen != rd_sent)
         report_value("completion starts", rd_sent, sop_seen);
      assert_fails = rp_shmem_target_inst.stream_chk_inst.fails;
      $display("Errors: %0d check, %0d assertion; %0d completions for %0d reads",
               errors, assert_fails, cpl_count, rd_sent);
      if ((errors == 0) && (assert_fails == 0))
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
rp_tlp_pkg.sv
rp_tlp_if.sv
rx_tlp_decoder.sv
shmem_ram.sv
cpl_tlp_builder.sv
rp_shmem_target.sv
tb_rp_shmem_target_chk.sv
tb_rp_shmem_target.sv

/* Bender.yml */
package:
  name: rp_shmem_target

sources:
  - files:
      - rp_tlp_pkg.sv
      - rp_tlp_if.sv
      - rx_tlp_decoder.sv
      - shmem_ram.sv
      - cpl_tlp_builder.sv
      - rp_shmem_target.sv
  - target: test
    files:
      - tb_rp_shmem_target_chk.sv
      - tb_rp_shmem_target.sv
